/* Makefile */
VERILATOR ?= verilator
TOP ?= armPipelineTb
FILELIST ?= armPipeline.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

FAIL_MSG := Done: errors found
PASS_MSG := Done: no errors
SOURCES := $(shell cat $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* armPipeline.f */
verilog/isaPkg.sv
verilog/pipelinePkg.sv
verilog/lookaheadAdder.sv
verilog/instructionDecoder.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/armPipeline.sv
verification/armPipeline_properties.sv
verification/armPipelineTb.sv

/* verification/armPipelineTb.sv */
`default_nettype none

module armPipelineTb;
    import isaPkg::*;
    import pipelinePkg::*;

    localparam int romDepth = 256;
    localparam addrT romBytes = addrT'(romDepth * 4);
    localparam int drainCycles = 48;
    localparam instrT nop = '0;

    typedef struct packed {
        addrT address;
        wordT value;
    } storeT;

    logic clk;
    logic reset;
    instrT instruction;
    addrT instrAddr;
    wordT dataRead;
    dataRequestT dataBus;

    instrT rom [romDepth];
    wordT dataMem [addrT];
    wordT modelRegs [32];

    instrT progWords[$];
    storeT storeLog[$];
    storeT expStores[$];
    addrT loadLog[$];
    addrT expLoads[$];

    int testErrors;
    int totalErrors;
    int testCount;
    int failedTests;

    armPipeline DUT (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .instrAddr(instrAddr),
        .dataRead(dataRead),
        .dataBus(dataBus)
    );

    always #20 clk = ~clk;

    // Instruction ROM with NOPs past its end
    always_comb
    begin
        if (instrAddr < romBytes)
            instruction = rom[instrAddr[9:2]];
        else
            instruction = nop;
    end

    // Unwritten locations return a pattern of the full address
    function automatic wordT peekWord(addrT address);
        wordT value;
        if (dataMem.exists(address))
            value = dataMem[address];
        else
            value = (address * 64'h9e37_79b9_7f4a_7c15) ^ 64'h5a3c_96e1_0f87_d24b;
        return value;
    endfunction

    always_comb dataRead = peekWord(dataBus.address);

    task automatic valueError(input string name, input string what,
                              input wordT expected, input wordT actual);
        testErrors++;
        $display("Error %s: %s expected %h, actual %h", name, what, expected, actual);
    endtask

    task automatic failure(input string name, input string what);
        testErrors++;
        $display("Error %s: %s", name, what);
    endtask

    // Instruction encoders
    function automatic instrT encodeR(logic [4:0] funct, regIndexT rd, regIndexT rn,
                                      regIndexT rm, logic [5:0] shamt);
        return {rFormat, funct, rm, shamt, rn, rd};
    endfunction

    function automatic instrT encodeI(logic [3:0] funct, regIndexT rd, regIndexT rn,
                                      logic [11:0] imm);
        return {iFormat, funct, imm, rn, rd};
    endfunction

    function automatic instrT encodeD(logic [4:0] funct, regIndexT rt, regIndexT rn,
                                      logic [8:0] offset);
        return {dFormat, funct, offset, 2'b00, rn, rt};
    endfunction

    // Two NOPs after each instruction keep producers and consumers apart
    task automatic emit(input instrT word);
        progWords.push_back(word);
        progWords.push_back(nop);
        progWords.push_back(nop);
    endtask

    function automatic wordT regValue(regIndexT index);
        return (index == zeroReg) ? '0 : modelRegs[index];
    endfunction

    task automatic setReg(input regIndexT index, input wordT value);
        if (index != zeroReg)
            modelRegs[index] = value;
    endtask

    task automatic regOp(input logic [4:0] funct, input regIndexT rd, input regIndexT rn,
                         input regIndexT rm, input logic [5:0] shamt);
        wordT a;
        wordT b;
        wordT result;
        a = regValue(rn);
        b = regValue(rm);
        case (funct)
            rAdd: result = a + b;
            rSub: result = a - b;
            rAnd: result = a & b;
            rOrr: result = a | b;
            rEor: result = a ^ b;
            rLsl: result = a << shamt;
            rLsr: result = a >> shamt;
            default: result = a;
        endcase
        setReg(rd, result);
        emit(encodeR(funct, rd, rn, rm, shamt));
    endtask

    task automatic immOp(input logic [3:0] funct, input regIndexT rd, input regIndexT rn,
                         input logic [11:0] imm);
        wordT a;
        wordT b;
        wordT result;
        a = regValue(rn);
        b = {{52{imm[11]}}, imm};
        case (funct)
            iAddi: result = a + b;
            iSubi: result = a - b;
            iAndi: result = a & b;
            iOrri: result = a | b;
            iEori: result = a ^ b;
            default: result = a;
        endcase
        setReg(rd, result);
        emit(encodeI(funct, rd, rn, imm));
    endtask

    task automatic load(input regIndexT rt, input regIndexT rn, input logic [8:0] offset);
        addrT address;
        address = regValue(rn) + {{55{offset[8]}}, offset};
        expLoads.push_back(address);
        setReg(rt, peekWord(address));
        emit(encodeD(dLdur, rt, rn, offset));
    endtask

    task automatic store(input regIndexT rt, input regIndexT rn, input logic [8:0] offset);
        addrT address;
        address = regValue(rn) + {{55{offset[8]}}, offset};
        expStores.push_back({address, regValue(rt)});
        emit(encodeD(dStur, rt, rn, offset));
    endtask

    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic loadRom();
        foreach (rom[i])
        begin
            if (i < progWords.size())
                rom[i] = progWords[i];
            else
                rom[i] = nop;
        end
    endtask

    // Memory side of the data port sampled mid-cycle
    task automatic sampleBus();
        if (dataBus.writeEnable)
        begin
            dataMem[dataBus.address] = dataBus.writeData;
            storeLog.push_back({dataBus.address, dataBus.writeData});
        end
        if (dataBus.readEnable)
            loadLog.push_back(dataBus.address);
    endtask

    task automatic startTest();
        testErrors = 0;
        progWords.delete();
        storeLog.delete();
        expStores.delete();
        loadLog.delete();
        expLoads.delete();
        dataMem.delete();
        foreach (modelRegs[i])
        begin
            modelRegs[i] = '0;
        end
    endtask

    task automatic runProgram(input string name);
        addrT endAddr;
        int cycles;
        assert (progWords.size() < romDepth)
            else failure(name, "program does not fit in the instruction ROM");
        loadRom();
        applyReset();
        endAddr = addrT'(progWords.size() * 4 + 16);
        cycles = 0;
        while (instrAddr < endAddr && cycles < progWords.size() + drainCycles)
        begin
            @(negedge clk);
            sampleBus();
            cycles++;
        end
        assert (instrAddr >= endAddr)
            else failure(name, "program did not run to its end within the cycle limit");
    endtask

    task automatic compareStores(input string name);
        assert (storeLog.size() == expStores.size())
            else valueError(name, "store count", 64'(expStores.size()), 64'(storeLog.size()));
        for (int i = 0; i < expStores.size() && i < storeLog.size(); i++)
        begin
            assert (storeLog[i].address == expStores[i].address)
                else valueError(name, $sformatf("store %0d address", i),
                                expStores[i].address, storeLog[i].address);
            assert (storeLog[i].value == expStores[i].value)
                else valueError(name, $sformatf("store %0d value", i),
                                expStores[i].value, storeLog[i].value);
        end
    endtask

    task automatic compareLoads(input string name);
        assert (loadLog.size() == expLoads.size())
            else valueError(name, "load count", 64'(expLoads.size()), 64'(loadLog.size()));
        for (int i = 0; i < expLoads.size() && i < loadLog.size(); i++)
        begin
            assert (loadLog[i] == expLoads[i])
                else valueError(name, $sformatf("load %0d address", i), expLoads[i], loadLog[i]);
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        totalErrors += testErrors;
        if (testErrors != 0)
            failedTests++;
        $display("Test %s: %s, %0d errors", name, (testErrors == 0) ? "passed" : "FAILED",
                 testErrors);
    endtask

    task automatic resetFetch();
        startTest();
        loadRom();
        applyReset();
        for (int i = 0; i < 24; i++)
        begin
            @(negedge clk);
            assert (instrAddr == addrT'(i * 4))
                else valueError("resetFetch", "instrAddr", addrT'(i * 4), instrAddr);
            assert (!dataBus.readEnable && !dataBus.writeEnable)
                else failure("resetFetch", "a data strobe went high while only NOPs ran");
        end
        finishTest("resetFetch");
    endtask

    task automatic registerAlu();
        startTest();
        immOp(iAddi, 5'd10, zeroReg, 12'h100);
        for (int r = 1; r <= 5; r++)
        begin
            immOp(iAddi, 5'(r), zeroReg, 12'($urandom_range(1, 2047)));
        end
        regOp(rAdd, 5'd6, 5'd1, 5'd2, 6'd0);
        regOp(rSub, 5'd7, 5'd3, 5'd4, 6'd0);
        regOp(rAnd, 5'd8, 5'd2, 5'd5, 6'd0);
        regOp(rOrr, 5'd9, 5'd1, 5'd4, 6'd0);
        regOp(rEor, 5'd11, 5'd3, 5'd5, 6'd0);
        store(5'd6, 5'd10, 9'd0);
        store(5'd7, 5'd10, 9'd8);
        store(5'd8, 5'd10, 9'd16);
        store(5'd9, 5'd10, 9'd24);
        store(5'd11, 5'd10, 9'd32);
        runProgram("registerAlu");
        compareStores("registerAlu");
        finishTest("registerAlu");
    endtask

    task automatic immediateShift();
        startTest();
        immOp(iAddi, 5'd10, zeroReg, 12'h200);
        // Top bit set so both immediates are negative
        immOp(iAddi, 5'd1, zeroReg, 12'h800 | 12'($urandom_range(0, 2047)));
        immOp(iSubi, 5'd2, 5'd1, 12'h800 | 12'($urandom_range(0, 2047)));
        immOp(iAndi, 5'd3, 5'd1, 12'($urandom));
        immOp(iOrri, 5'd4, 5'd2, 12'($urandom));
        immOp(iEori, 5'd5, 5'd1, 12'($urandom));
        regOp(rLsl, 5'd6, 5'd1, zeroReg, 6'($urandom));
        regOp(rLsr, 5'd7, 5'd2, zeroReg, 6'($urandom));
        for (int r = 1; r <= 7; r++)
        begin
            store(5'(r), 5'd10, 9'(r * 8));
        end
        runProgram("immediateShift");
        compareStores("immediateShift");
        finishTest("immediateShift");
    endtask

    task automatic loadStore();
        startTest();
        for (int k = 0; k <= 8; k++)
        begin
            dataMem[addrT'(12'h220 + k * 8)] = {$urandom, $urandom};
        end
        immOp(iAddi, 5'd10, zeroReg, 12'h240);
        load(5'd1, 5'd10, 9'd16);
        load(5'd2, 5'd10, 9'h1e8);
        load(5'd3, 5'd10, 9'h1f8);
        regOp(rAdd, 5'd4, 5'd1, 5'd2, 6'd0);
        regOp(rAdd, 5'd5, 5'd4, 5'd3, 6'd0);
        store(5'd4, 5'd10, 9'd64);
        store(5'd5, 5'd10, 9'd72);
        runProgram("loadStore");
        compareLoads("loadStore");
        compareStores("loadStore");
        finishTest("loadStore");
    endtask

    task automatic zeroRegUnknown();
        startTest();
        immOp(iAddi, 5'd10, zeroReg, 12'h300);
        immOp(iAddi, 5'd5, zeroReg, 12'($urandom_range(1, 2047)));
        immOp(iAddi, zeroReg, zeroReg, 12'($urandom_range(1, 2047)));
        store(zeroReg, 5'd10, 9'd0);
        // Undefined format aimed at X5 then an R word with an unused function code
        emit({6'b111111, 16'($urandom), 5'd5, 5'd5});
        emit(encodeR(5'd31, 5'd5, 5'd5, 5'd5, 6'd0));
        store(5'd5, 5'd10, 9'd8);
        runProgram("zeroRegUnknown");
        compareLoads("zeroRegUnknown");
        compareStores("zeroRegUnknown");
        finishTest("zeroRegUnknown");
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        testErrors = 0;
        totalErrors = 0;
        testCount = 0;
        failedTests = 0;
        foreach (rom[i])
        begin
            rom[i] = nop;
        end
        void'($urandom(68254));

        resetFetch();
        registerAlu();
        immediateShift();
        loadStore();
        zeroRegUnknown();

        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failedTests,
                 totalErrors);
        if (totalErrors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/armPipeline_properties.sv */
`default_nettype none

module armPipeline_properties (
    input logic                      clk,
    input logic                      reset,
    input pipelinePkg::addrT         instrAddr,
    input pipelinePkg::dataRequestT  dataBus
);
    import pipelinePkg::*;

    wordAligned: assert property (@(posedge clk) disable iff (reset)
        instrAddr[1:0] == 2'b00)
        else $error("instrAddr is not word-aligned");

    // One step per cycle once reset has dropped
    pcSteps: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> instrAddr == $past(instrAddr) + pcStep)
        else $error("instrAddr did not advance by one instruction");

    strobesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(dataBus.readEnable && dataBus.writeEnable))
        else $error("readEnable and writeEnable high together");

    quietInReset: assert property (@(posedge clk)
        reset && $past(reset) |-> !dataBus.readEnable && !dataBus.writeEnable)
        else $error("data strobe high during reset");

endmodule

bind armPipeline armPipeline_properties props (
    .clk(clk),
    .reset(reset),
    .instrAddr(instrAddr),
    .dataBus(dataBus)
);

`default_nettype wire

/* verilog/armPipeline.sv */
`default_nettype none

module armPipeline (
    input  logic                      clk,
    input  logic                      reset,
    input  isaPkg::instrT             instruction,
    output pipelinePkg::addrT         instrAddr,
    input  pipelinePkg::wordT         dataRead,
    output pipelinePkg::dataRequestT  dataBus
);
    import isaPkg::*;
    import pipelinePkg::*;

    addrT pc;
    instrT ifIdInstr;
    idExT idEx;
    exMemT exMem;
    memWbT memWb;

    regIndexT readRegA;
    regIndexT readRegB;
    controlT decodedControl;
    wordT decodedImmediate;
    wordT operandA;
    wordT operandB;
    wordT aluResult;
    wordT storeData;
    wordT writeData;

    // Fetch
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
            ifIdInstr <= '0;
        end
        else
        begin
            pc <= pc + pcStep;
            ifIdInstr <= instruction;
        end
    end

    assign instrAddr = pc;

    // Decode and operand read
    instructionDecoder decoder (
        .instruction(ifIdInstr),
        .readRegA(readRegA),
        .readRegB(readRegB),
        .control(decodedControl),
        .immediate(decodedImmediate)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .readRegA(readRegA),
        .readRegB(readRegB),
        .writeReg(memWb),
        .operandA(operandA),
        .operandB(operandB)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            idEx <= '0;
        else
            idEx <= '{control: decodedControl, operandA: operandA,
                      operandB: operandB, immediate: decodedImmediate};
    end

    // Execute
    executeUnit alu (
        .stage(idEx),
        .aluResult(aluResult),
        .storeData(storeData)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            exMem <= '0;
        else
            exMem <= '{control: idEx.control, aluResult: aluResult, storeData: storeData};
    end

    // Memory stage drives the data port straight from EX/MEM
    assign dataBus = '{address: exMem.aluResult,
                       writeData: exMem.storeData,
                       writeEnable: exMem.control.memWrite,
                       readEnable: exMem.control.memRead};

    assign writeData = exMem.control.memRead ? dataRead : exMem.aluResult;

    // Writeback register feeds the register file write port
    always_ff @(posedge clk)
    begin
        if (reset)
            memWb <= '0;
        else
            memWb <= '{regWrite: exMem.control.regWrite,
                       destReg: exMem.control.destReg,
                       writeData: writeData};
    end

endmodule

`default_nettype wire

/* verilog/executeUnit.sv */
`default_nettype none

module executeUnit (
    input  pipelinePkg::idExT  stage,
    output pipelinePkg::wordT  aluResult,
    output pipelinePkg::wordT  storeData
);
    import isaPkg::*;
    import pipelinePkg::*;

    wordT secondOperand;
    wordT adderOperand;
    wordT adderSum;
    logic subtract;
    logic [shiftWidth-1:0] shiftAmount;

    assign secondOperand = stage.control.useImm ? stage.immediate : stage.operandB;

    // a - b as a + ~b + 1
    assign subtract = (stage.control.aluOp == opSub);
    assign adderOperand = subtract ? ~secondOperand : secondOperand;

    lookaheadAdder #(.width(wordWidth)) adder (
        .a(stage.operandA),
        .b(adderOperand),
        .carryIn(subtract),
        .sum(adderSum),
        .groupGenerate(),
        .groupPropagate()
    );

    assign shiftAmount = secondOperand[shiftWidth-1:0];

    always_comb
    begin
        case (stage.control.aluOp)
            opAdd, opSub: aluResult = adderSum;
            opAnd: aluResult = stage.operandA & secondOperand;
            opOrr: aluResult = stage.operandA | secondOperand;
            opEor: aluResult = stage.operandA ^ secondOperand;
            opLsl: aluResult = stage.operandA << shiftAmount;
            opLsr: aluResult = stage.operandA >> shiftAmount;
            default: aluResult = adderSum;
        endcase
    end

    // Store value read through the B port
    assign storeData = stage.operandB;

endmodule

`default_nettype wire

/* verilog/instructionDecoder.sv */
`default_nettype none

module instructionDecoder (
    input  isaPkg::instrT         instruction,
    output isaPkg::regIndexT      readRegA,
    output isaPkg::regIndexT      readRegB,
    output pipelinePkg::controlT  control,
    output pipelinePkg::wordT     immediate
);
    import isaPkg::*;
    import pipelinePkg::*;

    logic [formatWidth-1:0] formatCode;
    logic [functWidth-1:0] funct;
    logic [iFunctWidth-1:0] iFunct;
    regIndexT rd;
    regIndexT rm;
    wordT aluImm;
    wordT dOffset;
    wordT shamt;
    logic known;

    assign formatCode = instruction[formatLsb +: formatWidth];
    assign funct = instruction[functLsb +: functWidth];
    assign iFunct = instruction[iFunctLsb +: iFunctWidth];
    assign rd = instruction[rdLsb +: regIndexWidth];
    assign rm = instruction[rmLsb +: regIndexWidth];
    assign readRegA = instruction[rnLsb +: regIndexWidth];

    // Immediate candidates
    assign aluImm = {{(wordWidth-aluImmWidth){instruction[aluImmLsb+aluImmWidth-1]}},
                     instruction[aluImmLsb +: aluImmWidth]};
    assign dOffset = {{(wordWidth-dOffsetWidth){instruction[dOffsetLsb+dOffsetWidth-1]}},
                      instruction[dOffsetLsb +: dOffsetWidth]};
    assign shamt = {{(wordWidth-shamtWidth){1'b0}}, instruction[shamtLsb +: shamtWidth]};

    always_comb
    begin
        control = '0;
        immediate = '0;
        readRegB = rm;
        known = 1'b1;
        case (formatCode)
            rFormat:
            begin
                control.regWrite = 1'b1;
                case (funct)
                    rAdd: control.aluOp = opAdd;
                    rSub: control.aluOp = opSub;
                    rAnd: control.aluOp = opAnd;
                    rOrr: control.aluOp = opOrr;
                    rEor: control.aluOp = opEor;
                    rLsl, rLsr:
                    begin
                        // Shift amount comes from the instruction, not Rm
                        control.aluOp = (funct == rLsl) ? opLsl : opLsr;
                        control.useImm = 1'b1;
                        immediate = shamt;
                    end
                    default: known = 1'b0;
                endcase
            end
            iFormat:
            begin
                control.regWrite = 1'b1;
                control.useImm = 1'b1;
                immediate = aluImm;
                case (iFunct)
                    iAddi: control.aluOp = opAdd;
                    iSubi: control.aluOp = opSub;
                    iAndi: control.aluOp = opAnd;
                    iOrri: control.aluOp = opOrr;
                    iEori: control.aluOp = opEor;
                    default: known = 1'b0;
                endcase
            end
            dFormat:
            begin
                control.aluOp = opAdd;
                control.useImm = 1'b1;
                immediate = dOffset;
                case (funct)
                    dLdur:
                    begin
                        control.regWrite = 1'b1;
                        control.memRead = 1'b1;
                    end
                    dStur:
                    begin
                        // Rd holds the value to store
                        control.memWrite = 1'b1;
                        readRegB = rd;
                    end
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase

        if (!known)
        begin
            control = '0;
            immediate = '0;
        end
        else
        begin
            control.destReg = rd;
            if (rd == zeroReg)
            begin
                control.regWrite = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef logic [31:0] instrT;
    typedef logic [4:0] regIndexT;

    // Always reads as zero, writes are dropped
    localparam regIndexT zeroReg = 5'd31;

    // Format codes in bits 31:26
    localparam int formatLsb = 26;
    localparam int formatWidth = 6;
    localparam logic [5:0] rFormat = 6'b001010;
    localparam logic [5:0] iFormat = 6'b100010;
    localparam logic [5:0] dFormat = 6'b110100;

    // R and D function codes in bits 25:21
    localparam int functLsb = 21;
    localparam int functWidth = 5;
    localparam logic [4:0] rAdd = 5'd0;
    localparam logic [4:0] rAnd = 5'd2;
    localparam logic [4:0] rEor = 5'd4;
    localparam logic [4:0] rLsl = 5'd6;
    localparam logic [4:0] rLsr = 5'd7;
    localparam logic [4:0] rOrr = 5'd8;
    localparam logic [4:0] rSub = 5'd9;
    localparam logic [4:0] dLdur = 5'd0;
    localparam logic [4:0] dStur = 5'd1;

    // I function codes in bits 25:22
    localparam int iFunctLsb = 22;
    localparam int iFunctWidth = 4;
    localparam logic [3:0] iAddi = 4'd0;
    localparam logic [3:0] iAndi = 4'd2;
    localparam logic [3:0] iEori = 4'd4;
    localparam logic [3:0] iOrri = 4'd6;
    localparam logic [3:0] iSubi = 4'd7;

    // Operand fields
    localparam int regIndexWidth = 5;
    localparam int rdLsb = 0;
    localparam int rnLsb = 5;
    localparam int rmLsb = 16;
    localparam int shamtLsb = 10;
    localparam int shamtWidth = 6;
    localparam int aluImmLsb = 10;
    localparam int aluImmWidth = 12;
    localparam int dOffsetLsb = 12;
    localparam int dOffsetWidth = 9;

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOrr,
        opEor,
        opLsl,
        opLsr
    } aluOpT;

endpackage

`default_nettype wire

/* verilog/lookaheadAdder.sv */
`default_nettype none

module lookaheadAdder #(
    parameter int width = pipelinePkg::wordWidth
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             carryIn,
    output logic [width-1:0] sum,
    output logic             groupGenerate,
    output logic             groupPropagate
);
    localparam int half = width / 2;

    if (width == 2)
    begin : leaf
        logic [1:0] bitGen;
        logic [1:0] bitProp;
        logic innerCarry;

        assign bitGen = a & b;
        assign bitProp = a ^ b;
        assign innerCarry = bitGen[0] | (bitProp[0] & carryIn);
        assign sum = {bitProp[1] ^ innerCarry, bitProp[0] ^ carryIn};
        assign groupGenerate = bitGen[1] | (bitProp[1] & bitGen[0]);
        assign groupPropagate = bitProp[1] & bitProp[0];
    end
    else
    begin : node
        logic lowGen;
        logic lowProp;
        logic highGen;
        logic highProp;
        logic midCarry;

        lookaheadAdder #(.width(half)) lowHalf (
            .a(a[half-1:0]),
            .b(b[half-1:0]),
            .carryIn(carryIn),
            .sum(sum[half-1:0]),
            .groupGenerate(lowGen),
            .groupPropagate(lowProp)
        );

        // Upper carry from the low group terms, no ripple through the low half
        assign midCarry = lowGen | (lowProp & carryIn);

        lookaheadAdder #(.width(half)) highHalf (
            .a(a[width-1:half]),
            .b(b[width-1:half]),
            .carryIn(midCarry),
            .sum(sum[width-1:half]),
            .groupGenerate(highGen),
            .groupPropagate(highProp)
        );

        assign groupGenerate = highGen | (highProp & lowGen);
        assign groupPropagate = highProp & lowProp;
    end

endmodule

`default_nettype wire

/* verilog/pipelinePkg.sv */
`default_nettype none

package pipelinePkg;

    localparam int wordWidth = 64;
    localparam int addrWidth = 64;
    localparam int shiftWidth = $clog2(wordWidth);

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [addrWidth-1:0] addrT;

    // Byte distance between consecutive instructions
    localparam addrT pcStep = 4;

    typedef struct packed {
        isaPkg::aluOpT aluOp;
        logic useImm;
        logic regWrite;
        logic memRead;
        logic memWrite;
        isaPkg::regIndexT destReg;
    } controlT;

    typedef struct packed {
        controlT control;
        wordT operandA;
        wordT operandB;
        wordT immediate;
    } idExT;

    typedef struct packed {
        controlT control;
        wordT aluResult;
        wordT storeData;
    } exMemT;

    typedef struct packed {
        logic regWrite;
        isaPkg::regIndexT destReg;
        wordT writeData;
    } memWbT;

    // Memory stage request, read data returns in the same cycle
    typedef struct packed {
        addrT address;
        wordT writeData;
        logic writeEnable;
        logic readEnable;
    } dataRequestT;

endpackage

`default_nettype wire

/* verilog/registerFile.sv */
`default_nettype none

module registerFile (
    input  logic                  clk,
    input  logic                  reset,
    input  isaPkg::regIndexT      readRegA,
    input  isaPkg::regIndexT      readRegB,
    input  pipelinePkg::memWbT    writeReg,
    output pipelinePkg::wordT     operandA,
    output pipelinePkg::wordT     operandB
);
    import isaPkg::*;
    import pipelinePkg::*;

    // X0 to X30, X31 has no storage
    wordT registers [zeroReg];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < zeroReg; i++)
            begin
                registers[i] <= '0;
            end
        end
        else if (writeReg.regWrite && writeReg.destReg != zeroReg)
        begin
            registers[writeReg.destReg] <= writeReg.writeData;
        end
    end

    // Bypass the value being written this cycle
    function automatic wordT readPort(regIndexT index);
        wordT value;
        if (index == zeroReg)
            value = '0;
        else if (writeReg.regWrite && writeReg.destReg == index)
            value = writeReg.writeData;
        else
            value = registers[index];
        return value;
    endfunction

    always_comb
    begin
        operandA = readPort(readRegA);
        operandB = readPort(readRegB);
    end

endmodule

`default_nettype wire
